//--- icache_top.f
verilog/icache_pkg.sv
verilog/icache_lookup_if.sv
verilog/refill_counter.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
sim/l2_model.sv
sim/icache_tb.sv

//--- sim/icache_tb.sv
module icache_tb
    import icache_pkg::*;
();

    localparam int sets       = 4;
    localparam int line_words = 4;
    localparam int max_wait   = 200;

    logic  clk = 1'b0;
    logic  nrst;
    logic  cpu_req;
    addr_t cpu_addr;
    logic  flush;
    logic  cpu_ack;
    logic  cpu_busy;
    data_t cpu_rdata;
    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_we;
    addr_t wb_adr;
    data_t wb_dat_i;
    logic  wb_ack;
    int    read_count;

    addr_t adr_log[$];    // wb_adr of each acked beat
    logic  cyc_seen;
    int    last_lat;

    always #2 clk = ~clk;

    icache_top #(
        .sets       (sets),
        .line_words (line_words)
    ) u_dut (
        .clk       (clk),
        .nrst      (nrst),
        .cpu_req   (cpu_req),
        .cpu_addr  (cpu_addr),
        .flush     (flush),
        .cpu_ack   (cpu_ack),
        .cpu_busy  (cpu_busy),
        .cpu_rdata (cpu_rdata),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .wb_ack    (wb_ack)
    );

    l2_model u_l2 (
        .clk        (clk),
        .nrst       (nrst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_o   (wb_dat_i),
        .wb_ack     (wb_ack),
        .read_count (read_count)
    );

    function automatic data_t expected_word(input addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic timeout_fail(input string what);
        cache_state_t st;
        st = u_dut.u_ctrl.state;
        $display("timeout while waiting for %s, controller in %s", what, st.name());
        $display("Regression failed");
        $fatal(1);
    endtask

    // one core read, checks data and hit or miss by beat count
    task automatic read_and_check(input addr_t a, input bit expect_hit);
        int    start_count;
        int    n;
        bit    got;
        data_t data;
        start_count = read_count;
        adr_log.delete();
        cyc_seen = 1'b0;
        n = 0;
        got = 1'b0;
        @(posedge clk);
        cpu_req  <= 1'b1;
        cpu_addr <= a;
        while (!got && n < max_wait)
        begin
            @(negedge clk);
            n++;
            check_value("wb_we", wb_we, 1'b0);
            if (wb_cyc)
                cyc_seen = 1'b1;
            if (wb_cyc && wb_stb && wb_ack)
                adr_log.push_back(wb_adr);
            if (cpu_ack)
            begin
                got  = 1'b1;
                data = cpu_rdata;
                check_value("cpu_busy", cpu_busy, 1'b1);
            end
        end
        if (!got)
            timeout_fail("cpu_ack");
        last_lat = n - 1;   // first sample is before the accepting edge
        @(posedge clk);
        cpu_req <= 1'b0;
        @(negedge clk);
        check_value("cpu_ack", cpu_ack, 1'b0);
        check_value("cpu_busy", cpu_busy, 1'b0);
        check_value("cpu_rdata", data, expected_word(a));
        check_value("beats", read_count - start_count, expect_hit ? 0 : line_words);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_value("cpu_ack", cpu_ack, 1'b0);
        check_value("cpu_busy", cpu_busy, 1'b0);
        check_value("wb_cyc", wb_cyc, 1'b0);
        check_value("wb_stb", wb_stb, 1'b0);
    endtask

    task automatic test_cold_miss();
        read_and_check(32'h0000_0104, 1'b0);
        check_value("beat_addrs", adr_log.size(), line_words);
        for (int i = 0; i < adr_log.size(); i++)
            check_value("wb_adr", adr_log[i], 32'h0000_0100 + 4 * i);
    endtask

    task automatic test_hit_timing();
        read_and_check(32'h0000_010c, 1'b1);
        check_value("ack_latency", last_lat, 1);
        check_value("wb_cyc_seen", cyc_seen, 1'b0);
    endtask

    // three lines in set 1
    task automatic test_replacement();
        read_and_check(32'h0000_1010, 1'b0);    // A to way 0
        read_and_check(32'h0000_2010, 1'b0);    // B to way 1
        read_and_check(32'h0000_1014, 1'b1);    // A again, B is lru
        read_and_check(32'h0000_3018, 1'b0);    // C evicts B
        read_and_check(32'h0000_301c, 1'b1);
        read_and_check(32'h0000_2010, 1'b0);
    endtask

    task automatic test_flush();
        read_and_check(32'h0000_0108, 1'b1);
        read_and_check(32'h0000_3010, 1'b1);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        read_and_check(32'h0000_0108, 1'b0);
        read_and_check(32'h0000_3010, 1'b0);
    endtask

    initial
    begin
        nrst     <= 1'b0;
        cpu_req  <= 1'b0;
        cpu_addr <= '0;
        flush    <= 1'b0;
        repeat (3) @(posedge clk);
        nrst <= 1'b1;
        test_reset_state();
        test_cold_miss();
        test_hit_timing();
        test_replacement();
        test_flush();
        $display("Regression passed");
        $finish;
    end

endmodule

//--- sim/l2_model.sv
module l2_model
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  nrst,
    input  logic  wb_cyc,
    input  logic  wb_stb,
    input  logic  wb_we,
    input  addr_t wb_adr,
    output data_t wb_dat_o,
    output logic  wb_ack,
    output int    read_count
);

    integer     seed;
    logic [1:0] wait_left;    // wait states before the next ack

    initial seed = 41;

    // registered ack, low for at least one cycle after each beat
    always @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            wb_ack     <= 1'b0;
            wb_dat_o   <= '0;
            wait_left  <= 2'd0;
            read_count <= 0;
        end
        else
        begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_we && !wb_ack)   // read-only slave
            begin
                if (wait_left == 2'd0)
                begin
                    wb_ack     <= 1'b1;
                    wb_dat_o   <= wb_adr ^ 32'h5a5a_0000;   // contents follow the address
                    read_count <= read_count + 1;
                    wait_left  <= $random(seed);           // low two bits, 0 to 3
                end
                else
                    wait_left <= wait_left - 2'd1;
            end
        end
    end

endmodule

//--- verilog/icache_ctrl.sv
module icache_ctrl
    import icache_pkg::*;
#(
    parameter int sets       = 4,
    parameter int line_words = 4
) (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          cpu_req,
    input  addr_t                         cpu_addr,
    input  logic                          flush,
    output logic                          cpu_ack,
    output logic                          cpu_busy,
    output data_t                         cpu_rdata,
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output logic                          wb_we,
    output addr_t                         wb_adr,
    input  data_t                         wb_dat_i,
    input  logic                          wb_ack,
    output logic                          cnt_clear,
    output logic                          cnt_step,
    input  logic [$clog2(line_words)-1:0] beat,
    input  logic                          last_beat,
    output logic                          wr_en,
    output logic [$clog2(sets)-1:0]       wr_set,
    output logic                          wr_way,
    output logic [$clog2(line_words)-1:0] wr_beat,
    output data_t                         wr_word,
    output logic [$clog2(sets)-1:0]       rd_set,
    output logic                          rd_way,
    output logic [$clog2(line_words)-1:0] rd_beat,
    input  data_t                         rd_word,
    icache_lookup_if.ctrl                 lk
);

    localparam int off_w   = $clog2(line_words);
    localparam int idx_w   = $clog2(sets);
    localparam int idx_lsb = off_w + 2;
    localparam int tag_lsb = idx_lsb + idx_w;

    cache_state_t state, next_state;
    addr_t        addr_q;
    logic         victim_q;
    logic         refill_done;
    logic         bus_ack;       // accepted refill beat
    logic         line_done;

    assign bus_ack   = (state == s_allocate) && wb_ack;
    assign line_done = bus_ack && last_beat;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            state <= s_idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            s_idle:
                if (cpu_req)
                    next_state = s_compare;
            s_compare:
                next_state = lk.hit ? s_idle : s_allocate;
            s_allocate:
                if (line_done)
                    next_state = s_compare; // lookup again, now hits
            default:
                next_state = s_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if ((state == s_idle) && cpu_req)
            addr_q <= cpu_addr;
    end

    // victim is fixed on the first compare only
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            victim_q    <= 1'b0;
            refill_done <= 1'b0;
        end
        else
        begin
            if ((state == s_compare) && !lk.hit && !refill_done)
                victim_q <= lk.victim_way;
            if (line_done)
                refill_done <= 1'b1;
            else if (state == s_idle)
                refill_done <= 1'b0;
        end
    end

    assign lk.index     = addr_q[tag_lsb-1:idx_lsb];
    assign lk.tag       = addr_q[addr_w-1:tag_lsb];
    assign lk.touch     = (state == s_compare) && lk.hit;
    assign lk.touch_way = lk.hit_way;
    assign lk.fill      = line_done;
    assign lk.fill_way  = victim_q;
    assign lk.flush     = (state == s_idle) && flush;

    assign cpu_ack   = (state == s_compare) && lk.hit;
    assign cpu_busy  = (state != s_idle);
    assign cpu_rdata = rd_word;

    assign rd_set  = addr_q[tag_lsb-1:idx_lsb];
    assign rd_way  = lk.hit_way;
    assign rd_beat = addr_q[idx_lsb-1:2];

    // one beat per word, address follows the counter
    assign wb_cyc = (state == s_allocate);
    assign wb_stb = (state == s_allocate);
    assign wb_we  = 1'b0;
    assign wb_adr = {addr_q[addr_w-1:idx_lsb], beat, 2'b00};

    assign cnt_clear = (state == s_compare) && !lk.hit;
    assign cnt_step  = bus_ack;

    assign wr_en   = bus_ack;
    assign wr_set  = addr_q[tag_lsb-1:idx_lsb];
    assign wr_way  = victim_q;
    assign wr_beat = beat;
    assign wr_word = wb_dat_i;

endmodule

//--- verilog/icache_data_array.sv
module icache_data_array
    import icache_pkg::*;
#(
    parameter int sets       = 4,
    parameter int line_words = 4
) (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic [$clog2(sets)-1:0]       wr_set,
    input  logic                          wr_way,
    input  logic [$clog2(line_words)-1:0] wr_beat,
    input  data_t                         wr_word,
    input  logic [$clog2(sets)-1:0]       rd_set,
    input  logic                          rd_way,
    input  logic [$clog2(line_words)-1:0] rd_beat,
    output data_t                         rd_word
);

    localparam int depth = sets * 2 * line_words;

    // word index is {set, way, beat}
    data_t mem [depth];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[{wr_set, wr_way, wr_beat}] <= wr_word;
    end

    assign rd_word = mem[{rd_set, rd_way, rd_beat}];   // async read

endmodule

//--- verilog/icache_lookup_if.sv
interface icache_lookup_if
    import icache_pkg::*;
#(
    parameter int sets       = 4,
    parameter int line_words = 4
);

    localparam int idx_w = $clog2(sets);
    localparam int tag_w = addr_w - 2 - $clog2(line_words) - idx_w;

    typedef logic [idx_w-1:0] index_t;
    typedef logic [tag_w-1:0] tag_t;

    index_t index;
    tag_t   tag;
    logic   hit;
    logic   hit_way;
    logic   victim_way;
    logic   touch;        // lru update
    logic   touch_way;
    logic   fill;         // tag write, sets valid
    logic   fill_way;
    logic   flush;

    modport ctrl (
        output index, tag, touch, touch_way, fill, fill_way, flush,
        input  hit, hit_way, victim_way
    );

    modport store (
        input  index, tag, touch, touch_way, fill, fill_way, flush,
        output hit, hit_way, victim_way
    );

endinterface

//--- verilog/icache_pkg.sv
package icache_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;

    typedef logic [addr_w-1:0] addr_t;   // byte address
    typedef logic [data_w-1:0] data_t;   // one instruction word

    // controller states
    typedef enum logic [1:0] {
        s_idle     = 2'b00,
        s_compare  = 2'b01,
        s_allocate = 2'b11
    } cache_state_t;

endpackage

//--- verilog/icache_tag_array.sv
module icache_tag_array #(
    parameter int sets = 4
) (
    input  logic           clk,
    input  logic           nrst,
    icache_lookup_if.store lk
);

    typedef lk.tag_t tag_t;

    tag_t            tag_mem [sets][2];
    logic [1:0]      valid [sets];
    logic [sets-1:0] lru;         // 0 -> replace way 0
    logic [1:0]      way_hit;

    always_comb
    begin
        for (int w = 0; w < 2; w++)
            way_hit[w] = valid[lk.index][w] && (tag_mem[lk.index][w] == lk.tag);
    end

    assign lk.hit     = |way_hit;
    assign lk.hit_way = ~way_hit[0]; // way 0 wins if both match

    // empty ways first, then lru
    always_comb
    begin
        if (!valid[lk.index][0])
            lk.victim_way = 1'b0;
        else if (!valid[lk.index][1])
            lk.victim_way = 1'b1;
        else
            lk.victim_way = lru[lk.index];
    end

    always_ff @(posedge clk)
    begin
        if (lk.fill)
            tag_mem[lk.index][lk.fill_way] <= lk.tag;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int s = 0; s < sets; s++)
                valid[s] <= 2'b00;
        end
        else if (lk.flush)
        begin
            for (int s = 0; s < sets; s++)
                valid[s] <= 2'b00;    // tags and lru stay
        end
        else if (lk.fill)
            valid[lk.index][lk.fill_way] <= 1'b1;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            lru <= '0;
        else if (lk.touch)
            lru[lk.index] <= ~lk.touch_way; // other way becomes lru
    end

endmodule

//--- verilog/icache_top.sv
module icache_top
    import icache_pkg::*;
#(
    parameter int sets       = 4,
    parameter int line_words = 4
) (
    input  logic  clk,
    input  logic  nrst,
    input  logic  cpu_req,
    input  addr_t cpu_addr,
    input  logic  flush,
    output logic  cpu_ack,
    output logic  cpu_busy,
    output data_t cpu_rdata,
    output logic  wb_cyc,
    output logic  wb_stb,
    output logic  wb_we,
    output addr_t wb_adr,
    input  data_t wb_dat_i,
    input  logic  wb_ack
);

    localparam int off_w = $clog2(line_words);
    localparam int idx_w = $clog2(sets);

    logic             cnt_clear;
    logic             cnt_step;
    logic [off_w-1:0] beat;
    logic             last_beat;
    logic             wr_en;
    logic [idx_w-1:0] wr_set;
    logic             wr_way;
    logic [off_w-1:0] wr_beat;
    data_t            wr_word;
    logic [idx_w-1:0] rd_set;
    logic             rd_way;
    logic [off_w-1:0] rd_beat;
    data_t            rd_word;

    icache_lookup_if #(
        .sets       (sets),
        .line_words (line_words)
    ) lk ();

    icache_ctrl #(
        .sets       (sets),
        .line_words (line_words)
    ) u_ctrl (
        .clk        (clk),
        .nrst       (nrst),
        .cpu_req    (cpu_req),
        .cpu_addr   (cpu_addr),
        .flush      (flush),
        .cpu_ack    (cpu_ack),
        .cpu_busy   (cpu_busy),
        .cpu_rdata  (cpu_rdata),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_ack     (wb_ack),
        .cnt_clear  (cnt_clear),
        .cnt_step   (cnt_step),
        .beat       (beat),
        .last_beat  (last_beat),
        .wr_en      (wr_en),
        .wr_set     (wr_set),
        .wr_way     (wr_way),
        .wr_beat    (wr_beat),
        .wr_word    (wr_word),
        .rd_set     (rd_set),
        .rd_way     (rd_way),
        .rd_beat    (rd_beat),
        .rd_word    (rd_word),
        .lk         (lk.ctrl)
    );

    icache_tag_array #(
        .sets (sets)
    ) u_tags (
        .clk  (clk),
        .nrst (nrst),
        .lk   (lk.store)
    );

    icache_data_array #(
        .sets       (sets),
        .line_words (line_words)
    ) u_data (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_set  (wr_set),
        .wr_way  (wr_way),
        .wr_beat (wr_beat),
        .wr_word (wr_word),
        .rd_set  (rd_set),
        .rd_way  (rd_way),
        .rd_beat (rd_beat),
        .rd_word (rd_word)
    );

    refill_counter #(
        .line_words (line_words)
    ) u_cnt (
        .clk       (clk),
        .nrst      (nrst),
        .clear     (cnt_clear),
        .step      (cnt_step),
        .beat      (beat),
        .last_beat (last_beat)
    );

endmodule

//--- verilog/refill_counter.sv
module refill_counter #(
    parameter int line_words = 4
) (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          clear,
    input  logic                          step,
    output logic [$clog2(line_words)-1:0] beat,
    output logic                          last_beat
);

    localparam int cnt_w = $clog2(line_words);

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            beat <= '0;
        else if (clear)
            beat <= '0;
        else if (step)
            beat <= beat + 1'b1;    // wraps to 0 after the last beat
    end

    assign last_beat = (beat == cnt_w'(line_words - 1));

endmodule
